// ==== Makefile ====
TOP := tb_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^Everything OK$$"

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir

// ==== design/axi_ts_top.sv ====
// Trigger sequencer top: register file, source select,
// sequencing state machine and timestamp block
`timescale 1ns/10ps

module axi_ts_top import ts_regs_pkg::*, ts_trig_pkg::*; #(
    parameter int AXI_ADDR_WIDTH = 12,
    parameter int NUM_EXT_TRIG   = 8
) (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic [AXI_ADDR_WIDTH-1:0] s_axi_awaddr,
    input  logic                      s_axi_awvalid,
    output logic                      s_axi_awready,
    input  word_t                     s_axi_wdata,
    input  logic                      s_axi_wvalid,
    output logic                      s_axi_wready,
    output axi_resp_t                 s_axi_bresp,
    output logic                      s_axi_bvalid,
    input  logic                      s_axi_bready,
    input  logic [AXI_ADDR_WIDTH-1:0] s_axi_araddr,
    input  logic                      s_axi_arvalid,
    output logic                      s_axi_arready,
    output word_t                     s_axi_rdata,
    output axi_resp_t                 s_axi_rresp,
    output logic                      s_axi_rvalid,
    input  logic                      s_axi_rready,
    input  logic [NUM_EXT_TRIG-1:0]   ext_trigger,    // Asynchronous levels
    input  rtc_t                      rtc_sec,
    input  rtc_t                      rtc_nsec,
    output logic                      measure_start,
    input  logic                      measure_done
);

    logic      init_pulse;
    logic      init_continuous;
    logic      abort_pulse;
    logic      arm_immediate;
    logic      trig_immediate;
    chan_sel_t arm_chan;
    chan_sel_t trig_chan;
    count_t    arm_count;
    count_t    trig_count;
    count_t    meas_count;
    logic      arm_event;
    logic      trig_event;
    status_t   status;
    rtc_t      ts_sec;
    rtc_t      ts_nsec;

    axil_trig_regs #(.AXI_ADDR_WIDTH(AXI_ADDR_WIDTH)) regs0 (.*);

    trig_source_sel #(.NUM_EXT_TRIG(NUM_EXT_TRIG)) src0 (.*);

    trig_seq_fsm fsm0 (.*);

    trig_timestamp ts0 (.*);

endmodule

// ==== design/axil_trig_regs.sv ====
// AXI4-Lite slave with control and layer config registers,
// status, timestamp and measurement count readback
`timescale 1ns/10ps

module axil_trig_regs import ts_regs_pkg::*, ts_trig_pkg::*; #(
    parameter int AXI_ADDR_WIDTH = 12
) (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic [AXI_ADDR_WIDTH-1:0] s_axi_awaddr,
    input  logic                      s_axi_awvalid,
    output logic                      s_axi_awready,
    input  word_t                     s_axi_wdata,
    input  logic                      s_axi_wvalid,
    output logic                      s_axi_wready,
    output axi_resp_t                 s_axi_bresp,
    output logic                      s_axi_bvalid,
    input  logic                      s_axi_bready,
    input  logic [AXI_ADDR_WIDTH-1:0] s_axi_araddr,
    input  logic                      s_axi_arvalid,
    output logic                      s_axi_arready,
    output word_t                     s_axi_rdata,
    output axi_resp_t                 s_axi_rresp,
    output logic                      s_axi_rvalid,
    input  logic                      s_axi_rready,
    output logic                      init_pulse,
    output logic                      init_continuous,
    output logic                      abort_pulse,
    output logic                      arm_immediate,
    output chan_sel_t                 arm_chan,
    output count_t                    arm_count,
    output logic                      trig_immediate,
    output chan_sel_t                 trig_chan,
    output count_t                    trig_count,
    input  status_t                   status,
    input  rtc_t                      ts_sec,
    input  rtc_t                      ts_nsec,
    input  count_t                    meas_count
);

    typedef logic [AXI_ADDR_WIDTH-1:0] addr_t;

    addr_t wr_addr;
    addr_t rd_addr;
    logic  wr_start;   // Both write channels present, nothing pending
    logic  wr_hs;
    logic  rd_hs;
    logic  wr_ok;
    logic  rd_ok;
    word_t rd_word;

    // Shared layout of ARM_CFG and TRIG_CFG
    function automatic word_t cfg_word(input logic imm, input chan_sel_t chan);
        word_t w;
        w = '0;
        w[CFG_IMM_BIT] = imm;
        w[CFG_CHAN_LSB +: $bits(chan_sel_t)] = chan;
        return w;
    endfunction

    assign wr_addr  = {s_axi_awaddr[AXI_ADDR_WIDTH-1:2], 2'b00};
    assign rd_addr  = {s_axi_araddr[AXI_ADDR_WIDTH-1:2], 2'b00};
    assign wr_start = s_axi_awvalid && s_axi_wvalid && !s_axi_awready && !s_axi_bvalid;
    assign wr_hs    = s_axi_awready && s_axi_wready && s_axi_awvalid && s_axi_wvalid;
    assign rd_hs    = s_axi_arready && s_axi_arvalid;

    always_comb begin
        case (wr_addr)
            addr_t'(REG_CTRL), addr_t'(REG_ARM_CFG), addr_t'(REG_ARM_COUNT),
            addr_t'(REG_TRIG_CFG), addr_t'(REG_TRIG_COUNT): wr_ok = 1'b1;
            default: wr_ok = 1'b0;  // Read-only or unmapped
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            s_axi_bvalid  <= 1'b0;
        end else begin
            s_axi_awready <= wr_start;
            s_axi_wready  <= wr_start;
            if (wr_hs) begin
                s_axi_bvalid <= 1'b1;
            end else if (s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_hs) begin
            s_axi_bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            init_pulse      <= 1'b0;
            init_continuous <= 1'b0;
            abort_pulse     <= 1'b0;
            arm_immediate   <= 1'b0;
            arm_chan        <= '0;
            arm_count       <= '0;
            trig_immediate  <= 1'b0;
            trig_chan       <= '0;
            trig_count      <= '0;
        end else begin
            init_pulse  <= 1'b0;  // Self-clearing
            abort_pulse <= 1'b0;
            if (wr_hs) begin
                case (wr_addr)
                    addr_t'(REG_CTRL): begin
                        init_pulse      <= s_axi_wdata[CTRL_INIT_IMM_BIT];
                        init_continuous <= s_axi_wdata[CTRL_INIT_CONT_BIT];
                        abort_pulse     <= s_axi_wdata[CTRL_ABORT_BIT];
                    end
                    addr_t'(REG_ARM_CFG): begin
                        arm_immediate <= s_axi_wdata[CFG_IMM_BIT];
                        arm_chan      <= s_axi_wdata[CFG_CHAN_LSB +: $bits(chan_sel_t)];
                    end
                    addr_t'(REG_TRIG_CFG): begin
                        trig_immediate <= s_axi_wdata[CFG_IMM_BIT];
                        trig_chan      <= s_axi_wdata[CFG_CHAN_LSB +: $bits(chan_sel_t)];
                    end
                    addr_t'(REG_ARM_COUNT):  arm_count  <= count_t'(s_axi_wdata);
                    addr_t'(REG_TRIG_COUNT): trig_count <= count_t'(s_axi_wdata);
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        rd_word = '0;
        rd_ok   = 1'b1;
        case (rd_addr)
            addr_t'(REG_CTRL):       rd_word[CTRL_INIT_CONT_BIT] = init_continuous;
            addr_t'(REG_ARM_CFG):    rd_word = cfg_word(arm_immediate, arm_chan);
            addr_t'(REG_ARM_COUNT):  rd_word = word_t'(arm_count);
            addr_t'(REG_TRIG_CFG):   rd_word = cfg_word(trig_immediate, trig_chan);
            addr_t'(REG_TRIG_COUNT): rd_word = word_t'(trig_count);
            addr_t'(REG_STATUS):     rd_word = word_t'(status);
            addr_t'(REG_TS_SEC):     rd_word = word_t'(ts_sec);
            addr_t'(REG_TS_NSEC):    rd_word = word_t'(ts_nsec);
            addr_t'(REG_MEAS_COUNT): rd_word = word_t'(meas_count);
            default:                 rd_ok   = 1'b0;  // Data stays 0
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b0;
        end else begin
            s_axi_arready <= s_axi_arvalid && !s_axi_arready && !s_axi_rvalid;
            if (rd_hs) begin
                s_axi_rvalid <= 1'b1;
            end else if (s_axi_rready) begin
                s_axi_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_hs) begin
            s_axi_rdata <= rd_word;
            s_axi_rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

// ==== design/trig_seq_fsm.sv ====
// Arm and trigger layer state machine with its counters,
// measure_start generation and status flags
`timescale 1ns/10ps

module trig_seq_fsm import ts_trig_pkg::*; (
    input  logic    aclk,
    input  logic    aresetn,
    input  logic    init_pulse,
    input  logic    init_continuous,
    input  logic    abort_pulse,
    input  logic    arm_event,
    input  logic    trig_event,
    input  count_t  arm_count,
    input  count_t  trig_count,
    input  logic    measure_done,
    output logic    measure_start,
    output status_t status
);

    trig_state_t state;
    trig_state_t state_next;
    count_t      arm_cnt;       // Arm events accepted this sweep
    count_t      trig_cnt;      // Measurements done in this arm
    count_t      arm_target;
    count_t      trig_target;

    // A count of 0 runs the layer once
    assign arm_target  = (arm_count == '0) ? count_t'(1) : arm_count;
    assign trig_target = (trig_count == '0) ? count_t'(1) : trig_count;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= ST_RST;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        if (abort_pulse) begin
            state_next = ST_IDLE;
        end else begin
            case (state)
                ST_RST:        state_next = ST_IDLE;
                ST_IDLE:       state_next = (init_pulse || init_continuous) ? ST_INIT : ST_IDLE;
                ST_INIT:       state_next = ST_ARM_WAIT;
                ST_ARM_WAIT:   state_next = arm_event ? ST_TRIG_WAIT : ST_ARM_WAIT;
                ST_TRIG_WAIT:  state_next = trig_event ? ST_MEASURING : ST_TRIG_WAIT;
                ST_MEASURING:  state_next = measure_done ? ST_TRIG_CHECK : ST_MEASURING;
                ST_TRIG_CHECK: state_next = (trig_cnt >= trig_target) ? ST_ARM_CHECK : ST_TRIG_WAIT;
                ST_ARM_CHECK: begin
                    if (arm_cnt < arm_target) begin
                        state_next = ST_ARM_WAIT;
                    end else begin
                        state_next = init_continuous ? ST_INIT : ST_IDLE;  // Sweep end
                    end
                end
                default:       state_next = ST_RST;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            arm_cnt  <= '0;
            trig_cnt <= '0;
        end else begin
            case (state)
                ST_INIT: begin
                    arm_cnt  <= '0;
                    trig_cnt <= '0;
                end
                ST_ARM_WAIT: begin
                    if (arm_event) begin
                        arm_cnt <= arm_cnt + count_t'(1);
                    end
                end
                ST_MEASURING: begin
                    if (measure_done) begin
                        trig_cnt <= trig_cnt + count_t'(1);
                    end
                end
                ST_ARM_CHECK: trig_cnt <= '0;  // Fresh trigger layer per arm
                default: ;
            endcase
        end
    end

    // One cycle, on entry to ST_MEASURING
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            measure_start <= 1'b0;
        end else begin
            measure_start <= (state == ST_TRIG_WAIT) && (state_next == ST_MEASURING);
        end
    end

    // ST_INIT counts as sweeping so complete and sweeping never both drop
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            status <= '0;
        end else begin
            status[STAT_COMPLETE]  <= (state_next == ST_IDLE);
            status[STAT_SWEEPING]  <= state_next inside {ST_INIT, ST_ARM_WAIT, ST_ARM_CHECK,
                                                         ST_TRIG_WAIT, ST_TRIG_CHECK,
                                                         ST_MEASURING};
            status[STAT_WAIT_ARM]  <= (state_next == ST_ARM_WAIT);
            status[STAT_WAIT_TRIG] <= (state_next == ST_TRIG_WAIT);
            status[STAT_MEASURING] <= (state_next == ST_MEASURING);
        end
    end

endmodule

// ==== design/trig_source_sel.sv ====
// External trigger synchroniser, rising edge detect and layer source select
`timescale 1ns/10ps

module trig_source_sel import ts_trig_pkg::*; #(
    parameter int NUM_EXT_TRIG = 8
) (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  logic [NUM_EXT_TRIG-1:0] ext_trigger,
    input  logic                    arm_immediate,
    input  chan_sel_t               arm_chan,
    input  logic                    trig_immediate,
    input  chan_sel_t               trig_chan,
    output logic                    arm_event,
    output logic                    trig_event
);

    localparam int NUM_SEL = 2 ** $bits(chan_sel_t);

    logic [NUM_EXT_TRIG-1:0] sync_q1;
    logic [NUM_EXT_TRIG-1:0] sync_q2;
    logic [NUM_EXT_TRIG-1:0] prev_q;   // Last synchronised sample
    logic [NUM_SEL-1:0]      rise;     // Upper channels stay 0

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
            prev_q  <= '0;
        end else begin
            sync_q1 <= ext_trigger;
            sync_q2 <= sync_q1;
            prev_q  <= sync_q2;
        end
    end

    assign rise = NUM_SEL'(sync_q2 & ~prev_q);

    // Edge register, immediate overrides the channel
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            arm_event  <= 1'b0;
            trig_event <= 1'b0;
        end else begin
            arm_event  <= arm_immediate || rise[arm_chan];
            trig_event <= trig_immediate || rise[trig_chan];
        end
    end

endmodule

// ==== design/trig_timestamp.sv ====
// RTC capture on measurement start, measurement counter since init
`timescale 1ns/10ps

module trig_timestamp import ts_trig_pkg::*; (
    input  logic   aclk,
    input  logic   aresetn,
    input  logic   measure_start,
    input  logic   init_pulse,
    input  rtc_t   rtc_sec,
    input  rtc_t   rtc_nsec,
    output rtc_t   ts_sec,
    output rtc_t   ts_nsec,
    output count_t meas_count
);

    // RTC as seen in the measure_start cycle
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ts_sec  <= '0;
            ts_nsec <= '0;
        end else if (measure_start) begin
            ts_sec  <= rtc_sec;
            ts_nsec <= rtc_nsec;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            meas_count <= '0;
        end else if (init_pulse) begin
            meas_count <= '0;  // New run from software
        end else if (measure_start) begin
            meas_count <= meas_count + count_t'(1);
        end
    end

endmodule

// ==== design/ts_regs_pkg.sv ====
// Register map offsets, CTRL and CFG field positions, AXI response codes
package ts_regs_pkg;

    typedef logic [31:0] word_t;       // Register data width
    typedef logic [1:0]  axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // Byte offsets
    localparam logic [11:0] REG_CTRL       = 12'h000;
    localparam logic [11:0] REG_ARM_CFG    = 12'h004;
    localparam logic [11:0] REG_ARM_COUNT  = 12'h008;
    localparam logic [11:0] REG_TRIG_CFG   = 12'h00C;
    localparam logic [11:0] REG_TRIG_COUNT = 12'h010;
    localparam logic [11:0] REG_STATUS     = 12'h014;  // Read only
    localparam logic [11:0] REG_TS_SEC     = 12'h018;  // Last timestamp
    localparam logic [11:0] REG_TS_NSEC    = 12'h01C;
    localparam logic [11:0] REG_MEAS_COUNT = 12'h020;

    localparam int CTRL_INIT_IMM_BIT  = 0;  // Write-one pulse
    localparam int CTRL_INIT_CONT_BIT = 1;  // Stored level
    localparam int CTRL_ABORT_BIT     = 2;  // Write-one pulse

    // Shared by ARM_CFG and TRIG_CFG
    localparam int CFG_IMM_BIT  = 0;
    localparam int CFG_CHAN_LSB = 4;

endpackage

// ==== design/ts_trig_pkg.sv ====
// Trigger model types: sequencer states, counts, channel select, status
package ts_trig_pkg;

    typedef enum logic [2:0] {
        ST_RST,         // Leaving reset
        ST_IDLE,        // Waiting for init
        ST_INIT,        // Clear counters, start sweep
        ST_ARM_WAIT,
        ST_ARM_CHECK,   // Compare arm counter
        ST_TRIG_WAIT,
        ST_TRIG_CHECK,  // Compare trigger counter
        ST_MEASURING    // Waiting for measure_done
    } trig_state_t;

    typedef logic [31:0] count_t;
    typedef logic [3:0]  chan_sel_t;  // Values at or above NUM_EXT_TRIG never fire
    typedef logic [31:0] rtc_t;

    typedef logic [4:0]  status_t;

    // Status bit positions
    localparam int STAT_COMPLETE  = 0;
    localparam int STAT_SWEEPING  = 1;
    localparam int STAT_WAIT_ARM  = 2;
    localparam int STAT_WAIT_TRIG = 3;
    localparam int STAT_MEASURING = 4;

endpackage

// ==== tb.f ====
design/ts_regs_pkg.sv
design/ts_trig_pkg.sv
design/axil_trig_regs.sv
design/trig_source_sel.sv
design/trig_seq_fsm.sv
design/trig_timestamp.sv
design/axi_ts_top.sv
verif/tb_clock_gen.sv
verif/trig_seq_props.sv
verif/tb_top.sv

// ==== verif/tb_clock_gen.sv ====
// Testbench clock with 20 ns period, reset held low for 8 cycles
`timescale 1ns/10ps

module tb_clock_gen (
    output logic aclk,
    output logic aresetn
);

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    initial begin
        aresetn = 1'b0;
        repeat (8) @(negedge aclk);
        aresetn = 1'b1;  // Released on a falling edge
    end

endmodule

// ==== verif/tb_top.sv ====
// Trigger sequencer testbench with AXI tasks, device and RTC models,
// pulse monitor, reference function and checks
`timescale 1ns/10ps

module tb_top import ts_regs_pkg::*, ts_trig_pkg::*; ();

    localparam int    LIMIT     = 2000;           // Cycles per wait loop
    localparam word_t CFG_MASK  = 32'h0000_00F1;  // Immediate bit and channel
    localparam word_t ALL_BITS  = 32'hFFFF_FFFF;
    localparam word_t COMPLETE  = 32'h1;          // Status bits
    localparam word_t SWEEPING  = 32'h2;
    localparam word_t WAIT_TRIG = 32'h8;

    logic        aclk;
    logic        aresetn;
    logic [11:0] s_axi_awaddr;
    logic        s_axi_awvalid;
    logic        s_axi_awready;
    word_t       s_axi_wdata;
    logic        s_axi_wvalid;
    logic        s_axi_wready;
    axi_resp_t   s_axi_bresp;
    logic        s_axi_bvalid;
    logic        s_axi_bready;
    logic [11:0] s_axi_araddr;
    logic        s_axi_arvalid;
    logic        s_axi_arready;
    word_t       s_axi_rdata;
    axi_resp_t   s_axi_rresp;
    logic        s_axi_rvalid;
    logic        s_axi_rready;
    logic [7:0]  ext_trigger;
    rtc_t        rtc_sec;
    rtc_t        rtc_nsec;
    logic        measure_start;
    logic        measure_done;

    int          errors      = 0;
    int          timeouts    = 0;
    int          pulse_count = 0;   // measure_start pulses seen
    rtc_t        last_sec    = '0;  // RTC at the last pulse
    rtc_t        last_nsec   = '0;
    logic [31:0] stim_rng    = 32'd53356;
    logic [31:0] dev_rng     = 32'd53356;

    tb_clock_gen clk0 (.aclk(aclk), .aresetn(aresetn));

    axi_ts_top #(.AXI_ADDR_WIDTH(12), .NUM_EXT_TRIG(8)) dut0 (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Measurements in one sweep where a zero count runs its layer once
    function automatic int expected_meas(input int arm, input int trig);
        int a;
        int t;
        a = (arm == 0) ? 1 : arm;
        t = (trig == 0) ? 1 : trig;
        return a * t;
    endfunction

    task automatic report_mismatch(input string what, input word_t got, input word_t exp);
        errors++;
        $display("Error at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timeout at time %0t: gave up waiting for %s", $time, what);
    endtask

    task automatic axi_write(input logic [11:0] addr, input word_t data, output axi_resp_t resp);
        int timer;
        @(negedge aclk);
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        timer = 0;
        while (!(s_axi_awready && s_axi_wready) && timer < 50) begin
            @(negedge aclk);
            timer++;
        end
        if (!(s_axi_awready && s_axi_wready)) report_timeout("write address ready");
        @(negedge aclk);  // Handshake on the edge in between
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        timer = 0;
        while (!s_axi_bvalid && timer < 50) begin
            @(negedge aclk);
            timer++;
        end
        if (!s_axi_bvalid) report_timeout("write response");
        resp = s_axi_bresp;
    endtask

    task automatic axi_read(input logic [11:0] addr, output word_t data, output axi_resp_t resp);
        int timer;
        @(negedge aclk);
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        timer = 0;
        while (!s_axi_arready && timer < 50) begin
            @(negedge aclk);
            timer++;
        end
        if (!s_axi_arready) report_timeout("read address ready");
        @(negedge aclk);
        s_axi_arvalid = 1'b0;
        timer = 0;
        while (!s_axi_rvalid && timer < 50) begin
            @(negedge aclk);
            timer++;
        end
        if (!s_axi_rvalid) report_timeout("read data");
        data = s_axi_rdata;
        resp = s_axi_rresp;
    endtask

    task automatic write_ok(input logic [11:0] addr, input word_t data);
        axi_resp_t resp;
        axi_write(addr, data, resp);
        if (resp !== RESP_OKAY) begin
            report_mismatch($sformatf("write response at %0h", addr), word_t'(resp), 32'h0);
        end
    endtask

    task automatic read_ok(input logic [11:0] addr, output word_t data);
        axi_resp_t resp;
        axi_read(addr, data, resp);
        if (resp !== RESP_OKAY) begin
            report_mismatch($sformatf("read response at %0h", addr), word_t'(resp), 32'h0);
        end
    endtask

    task automatic check_rw(input logic [11:0] addr, input word_t mask);
        word_t val;
        word_t got;
        stim_rng = xorshift(stim_rng);
        val = stim_rng;
        write_ok(addr, val);
        read_ok(addr, got);
        if (got !== (val & mask)) begin
            report_mismatch($sformatf("readback at %0h", addr), got, val & mask);
        end
    endtask

    // Polls STATUS until one of the masked bits is set
    task automatic wait_status(input word_t mask, input string what);
        word_t st;
        int    polls;
        polls = 0;
        read_ok(REG_STATUS, st);
        while ((st & mask) == '0 && polls < 200) begin
            read_ok(REG_STATUS, st);
            polls++;
        end
        if ((st & mask) == '0) report_timeout(what);
    endtask

    task automatic wait_pulses(input int target);
        int timer;
        timer = 0;
        while (pulse_count < target && timer < LIMIT) begin
            @(negedge aclk);
            timer++;
        end
        if (pulse_count < target) report_timeout("measure_start pulses");
    endtask

    task automatic pulse_line(input logic [2:0] ch);
        @(negedge aclk);
        ext_trigger[ch] = 1'b1;
        repeat (4) @(negedge aclk);
        ext_trigger[ch] = 1'b0;
        repeat (4) @(negedge aclk);
    endtask

    task automatic run_immediate(input int arm, input int trig);
        int    start;
        int    exp_n;
        word_t got;
        exp_n = expected_meas(arm, trig);
        write_ok(REG_ARM_CFG, 32'h1);
        write_ok(REG_TRIG_CFG, 32'h1);
        write_ok(REG_ARM_COUNT, word_t'(arm));
        write_ok(REG_TRIG_COUNT, word_t'(trig));
        start = pulse_count;
        write_ok(REG_CTRL, 32'h1);
        wait_pulses(start + exp_n);
        wait_status(COMPLETE, "end of immediate sweep");
        read_ok(REG_STATUS, got);
        if ((got & (COMPLETE | SWEEPING)) !== COMPLETE) report_mismatch("status", got, COMPLETE);
        if (pulse_count - start != exp_n) begin
            report_mismatch("pulse count", word_t'(pulse_count - start), word_t'(exp_n));
        end
        read_ok(REG_MEAS_COUNT, got);
        if (got !== word_t'(exp_n)) report_mismatch("measurement count", got, word_t'(exp_n));
    endtask

    task automatic check_external();
        int    start;
        word_t got;
        write_ok(REG_ARM_CFG, 32'h1);
        write_ok(REG_ARM_COUNT, 32'd1);
        write_ok(REG_TRIG_CFG, 32'h50);  // Channel 5 without immediate
        write_ok(REG_TRIG_COUNT, 32'd2);
        start = pulse_count;
        write_ok(REG_CTRL, 32'h1);
        wait_status(WAIT_TRIG, "trigger wait");
        pulse_line(3'd0);
        pulse_line(3'd3);
        pulse_line(3'd7);
        if (pulse_count != start) begin
            report_mismatch("pulses from other lines", word_t'(pulse_count - start), 32'h0);
        end
        pulse_line(3'd5);
        wait_pulses(start + 1);
        wait_status(WAIT_TRIG, "second trigger wait");
        pulse_line(3'd5);
        wait_pulses(start + 2);
        wait_status(COMPLETE, "end of external sweep");
        if (pulse_count - start != 2) begin
            report_mismatch("external pulses", word_t'(pulse_count - start), 32'h2);
        end
        read_ok(REG_TS_SEC, got);
        if (got !== last_sec) report_mismatch("timestamp seconds", got, last_sec);
        read_ok(REG_TS_NSEC, got);
        if (got !== last_nsec) report_mismatch("timestamp nanoseconds", got, last_nsec);
    endtask

    task automatic check_abort();
        int    start;
        int    settled;
        int    full;
        word_t got;
        full = expected_meas(1, 10);
        write_ok(REG_ARM_CFG, 32'h1);
        write_ok(REG_TRIG_CFG, 32'h1);
        write_ok(REG_ARM_COUNT, 32'd1);
        write_ok(REG_TRIG_COUNT, 32'd10);
        start = pulse_count;
        write_ok(REG_CTRL, 32'h1);
        wait_pulses(start + 3);
        write_ok(REG_CTRL, 32'h4);
        wait_status(COMPLETE, "idle after abort");
        settled = pulse_count;
        if (settled - start >= full) begin
            errors++;
            $display("Error at time %0t: sweep ran all %0d measurements despite abort",
                     $time, full);
        end
        repeat (100) @(negedge aclk);
        if (pulse_count != settled) begin
            report_mismatch("pulses after abort", word_t'(pulse_count - settled), 32'h0);
        end
        read_ok(REG_MEAS_COUNT, got);
        if (got !== word_t'(settled - start)) begin
            report_mismatch("aborted count", got, word_t'(settled - start));
        end
    endtask

    task automatic check_continuous();
        int    start;
        int    n;
        word_t got;
        write_ok(REG_ARM_CFG, 32'h1);
        write_ok(REG_TRIG_CFG, 32'h1);
        write_ok(REG_ARM_COUNT, 32'd1);
        write_ok(REG_TRIG_COUNT, 32'd2);
        start = pulse_count;
        write_ok(REG_CTRL, 32'h3);  // Init and continuous
        wait_pulses(start + 6);
        write_ok(REG_CTRL, 32'h0);
        wait_status(COMPLETE, "end of continuous run");
        n = pulse_count - start;
        read_ok(REG_MEAS_COUNT, got);
        if (got !== word_t'(n)) report_mismatch("continuous count", got, word_t'(n));
        if ((n % expected_meas(1, 2)) != 0) begin
            errors++;
            $display("Error at time %0t: continuous run stopped inside a sweep after %0d", $time, n);
        end
    endtask

    // Free-running RTC
    initial begin
        rtc_nsec = '0;
        rtc_sec  = '0;
        forever begin
            @(negedge aclk);
            rtc_nsec = rtc_nsec + 32'd1;
            rtc_sec  = rtc_nsec >> 10;
        end
    end

    // Counts pulses and keeps the RTC value latched with each one
    always @(posedge aclk) begin
        if (aresetn && measure_start) begin
            pulse_count = pulse_count + 1;
            last_sec    = rtc_sec;
            last_nsec   = rtc_nsec;
        end
    end

    // Measuring device answers after 1 to 20 cycles
    initial begin
        logic [31:0] delay;
        measure_done = 1'b0;
        forever begin
            @(negedge aclk);
            measure_done = 1'b0;
            if (measure_start) begin
                dev_rng = xorshift(dev_rng);
                delay = 32'd1 + dev_rng % 32'd20;
                repeat (delay - 32'd1) @(negedge aclk);
                measure_done = 1'b1;
            end
        end
    end

    initial begin
        int        arm;
        int        trig;
        int        timer;
        word_t     got;
        axi_resp_t resp;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b1;  // Responses always accepted
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b1;
        ext_trigger   = '0;
        timer = 0;
        @(negedge aclk);
        while (!aresetn && timer < 50) begin
            @(negedge aclk);
            timer++;
        end
        if (!aresetn) report_timeout("reset release");

        read_ok(REG_STATUS, got);
        if (got !== COMPLETE) report_mismatch("status after reset", got, COMPLETE);
        repeat (2) begin
            check_rw(REG_ARM_CFG, CFG_MASK);
            check_rw(REG_ARM_COUNT, ALL_BITS);
            check_rw(REG_TRIG_CFG, CFG_MASK);
            check_rw(REG_TRIG_COUNT, ALL_BITS);
        end
        axi_write(12'h100, 32'h1234_5678, resp);
        if (resp !== RESP_SLVERR) report_mismatch("unmapped write response", word_t'(resp), 32'h2);
        axi_write(REG_STATUS, 32'h1F, resp);
        if (resp !== RESP_SLVERR) report_mismatch("status write response", word_t'(resp), 32'h2);
        axi_read(12'h100, got, resp);
        if (resp !== RESP_SLVERR) report_mismatch("unmapped read response", word_t'(resp), 32'h2);
        if (got !== '0) report_mismatch("unmapped read data", got, 32'h0);

        run_immediate(2, 3);
        repeat (3) begin
            stim_rng = xorshift(stim_rng);
            arm = int'(stim_rng % 32'd5);
            stim_rng = xorshift(stim_rng);
            trig = int'(stim_rng % 32'd5);
            run_immediate(arm, trig);
        end
        check_external();
        check_abort();
        check_continuous();

        errors = errors + dut0.fsm0.props0.fail_count;
        $display("Finished with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== verif/trig_seq_props.sv ====
// Concurrent assertions on the sequencing state machine, bound into trig_seq_fsm
`timescale 1ns/10ps

module trig_seq_props import ts_trig_pkg::*; (
    input logic        aclk,
    input logic        aresetn,
    input trig_state_t state,
    input logic        measure_start,
    input status_t     status
);

    int fail_count = 0;  // Read by the testbench at the end

    a_start_single: assert property (@(posedge aclk) disable iff (!aresetn)
        measure_start |=> !measure_start)
        else begin
            $error("measure_start high for two cycles in a row");
            fail_count++;
        end

    // Start only leaves the trigger wait state
    a_start_from_trig_wait: assert property (@(posedge aclk) disable iff (!aresetn)
        measure_start |-> $past(state) == ST_TRIG_WAIT)
        else begin
            $error("measure_start without a preceding trigger wait");
            fail_count++;
        end

    a_complete_or_sweeping: assert property (@(posedge aclk) disable iff (!aresetn)
        $past(aresetn) |-> (status[STAT_COMPLETE] ^ status[STAT_SWEEPING]))
        else begin
            $error("complete and sweeping flags not exclusive");
            fail_count++;
        end

endmodule

bind trig_seq_fsm trig_seq_props props0 (
    .aclk(aclk),
    .aresetn(aresetn),
    .state(state),
    .measure_start(measure_start),
    .status(status)
);
